//--- design/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine
    import i2c_bus_pkg::*;
    import i2c_xfer_pkg::*;
#(
    parameter int MEM_BYTES = 16
)(
    input  logic       I2C_CLK,
    input  logic       RST,
    i2c_xfer_if.engine xfer,
    i2c_mem_if.engine  mem,
    input  logic       sda_in,
    output logic       scl_low,
    output logic       sda_low
);

    localparam int AW = $clog2(MEM_BYTES);

    i2c_phase_t       phase;
    i2c_state_t       state;
    i2c_state_t       state_nx;
    logic             pending;
    logic             nack;
    logic [2:0]       bit_cnt;
    logic [LEN_W-1:0] byte_cnt;
    logic [LEN_W-1:0] wr_idx;
    logic [7:0]       rx_byte;
    logic             sda_bit;
    logic             sda_drv;
    logic             scl_hold;
    logic             last_bit;
    logic             last_byte;
    logic             is_read;

    assign last_bit  = (bit_cnt == 3'd7);
    assign last_byte = (byte_cnt == xfer.length);
    assign is_read   = xfer.addr_byte.f.rw;

    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE:     if (pending) state_nx = ST_START;
            ST_START:    state_nx = ST_ADDR;
            ST_ADDR:     if (last_bit) state_nx = ST_ADDR_ACK;
            ST_ADDR_ACK: begin
                if (sda_bit || xfer.length == '0)
                    state_nx = ST_STOP;
                else if (is_read)
                    state_nx = ST_RD_DATA;
                else
                    state_nx = ST_WR_DATA;
            end
            ST_WR_DATA:  if (last_bit) state_nx = ST_WR_ACK;
            ST_RD_DATA:  if (last_bit) state_nx = ST_RD_ACK;
            ST_WR_ACK:   state_nx = (sda_bit || last_byte) ? ST_STOP : ST_WR_DATA;
            ST_RD_ACK:   state_nx = last_byte ? ST_STOP : ST_RD_DATA;
            ST_STOP:     state_nx = ST_DONE;
            default:     state_nx = ST_IDLE;
        endcase
    end

    // SDA level for the coming bit, as drive-low
    always_comb begin
        sda_drv = 1'b0;
        case (state)
            ST_START:   sda_drv = 1'b1;
            ST_ADDR:    sda_drv = ~xfer.addr_byte.raw[3'd7 - bit_cnt];
            ST_WR_DATA: sda_drv = ~mem.rdata[3'd7 - bit_cnt];
            ST_RD_ACK:  sda_drv = !last_byte;
            ST_STOP:    sda_drv = 1'b1;
            default:    sda_drv = 1'b0;
        endcase
    end

    // SCL stays high through stop and done
    assign scl_hold = !(state inside {ST_IDLE, ST_STOP, ST_DONE});

    always_ff @(posedge I2C_CLK) begin
        if (RST) begin
            phase    <= PH_DRIVE;
            state    <= ST_IDLE;
            pending  <= 1'b0;
            nack     <= 1'b0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            scl_low  <= 1'b0;
            sda_low  <= 1'b0;
        end else begin
            phase <= i2c_phase_t'(phase + 2'd1);
            if (xfer.start) begin
                pending <= 1'b1;
            end
            case (phase)
                PH_DRIVE:    sda_low <= sda_drv;
                PH_SCL_RISE: scl_low <= 1'b0;
                PH_SCL_FALL: begin
                    scl_low <= scl_hold;
                    state   <= state_nx;
                    if (state == ST_IDLE && pending) begin
                        pending  <= 1'b0;
                        nack     <= 1'b0;
                        byte_cnt <= '0;
                    end
                    if (state inside {ST_ADDR, ST_WR_DATA, ST_RD_DATA}) begin
                        bit_cnt <= bit_cnt + 3'd1;
                    end
                    if (state inside {ST_WR_DATA, ST_RD_DATA} && last_bit) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                    if (state inside {ST_ADDR_ACK, ST_WR_ACK} && sda_bit) begin
                        nack <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Line sampling, one cycle after SCL went high
    always_ff @(posedge I2C_CLK) begin
        if (phase == PH_SAMPLE) begin
            sda_bit <= sda_in;
            if (state == ST_RD_DATA) begin
                rx_byte <= {rx_byte[6:0], sda_in};
            end
        end
    end

    // byte_cnt has already moved past the received byte
    assign wr_idx    = byte_cnt - 1'b1;
    assign mem.we    = (state == ST_RD_ACK) && (phase == PH_SAMPLE);
    assign mem.en    = mem.we || ((state == ST_WR_ACK || (state == ST_ADDR_ACK && !is_read))
                                  && phase == PH_SAMPLE);
    assign mem.addr  = mem.we ? wr_idx[AW-1:0] : byte_cnt[AW-1:0];
    assign mem.wdata = rx_byte;

    assign xfer.busy     = pending || (state != ST_IDLE);
    assign xfer.finished = (state == ST_DONE) && (phase == PH_SCL_FALL);
    assign xfer.no_ack   = nack;

endmodule

//--- design/i2c_bus_pkg.sv
package i2c_bus_pkg;

    // I2C_CLK cycles per SCL period
    localparam int QUARTERS_PER_BIT = 4;

    // Position inside one bit period
    typedef enum logic [$clog2(QUARTERS_PER_BIT)-1:0] {
        PH_DRIVE    = 2'd0,
        PH_SCL_RISE = 2'd1,
        PH_SAMPLE   = 2'd2,
        PH_SCL_FALL = 2'd3
    } i2c_phase_t;

    // One state lasts exactly one bit period, except the byte states
    typedef enum logic [3:0] {
        ST_IDLE     = 4'd0,
        ST_START    = 4'd1,
        ST_ADDR     = 4'd2,
        ST_ADDR_ACK = 4'd3,
        ST_WR_DATA  = 4'd4,
        ST_RD_DATA  = 4'd5,
        ST_WR_ACK   = 4'd6,
        ST_RD_ACK   = 4'd7,
        ST_STOP     = 4'd8,
        ST_DONE     = 4'd9
    } i2c_state_t;

endpackage

//--- design/i2c_cmd_port.sv
`timescale 1ns/1ps

module i2c_cmd_port
    import i2c_xfer_pkg::*;
(
    input  logic             I2C_CLK,
    input  logic             RST,
    input  logic             req,
    input  addr_byte_u       addr_byte,
    input  logic [LEN_W-1:0] length,
    output logic             ack,
    output logic             done,
    output logic             no_ack,
    i2c_xfer_if.port         xfer
);

    localparam logic [1:0] C_IDLE  = 2'd0;
    localparam logic [1:0] C_START = 2'd1;
    localparam logic [1:0] C_WAIT  = 2'd2;
    localparam logic [1:0] C_ACK   = 2'd3;

    logic [1:0]       cstate;
    addr_byte_u       cmd;
    logic [LEN_W-1:0] cmd_len;

    always_ff @(posedge I2C_CLK) begin
        if (RST) begin
            cstate <= C_IDLE;
            done   <= 1'b0;
            no_ack <= 1'b0;
        end else begin
            case (cstate)
                C_IDLE: if (req) begin
                    cstate <= C_START;
                    done   <= 1'b0;
                    no_ack <= 1'b0;
                end
                C_START: if (!xfer.busy) begin
                    cstate <= C_WAIT;
                end
                C_WAIT: if (xfer.finished) begin
                    done   <= !xfer.no_ack;
                    no_ack <= xfer.no_ack;
                    cstate <= C_ACK;
                end
                default: if (!req) begin
                    cstate <= C_IDLE;
                end
            endcase
        end
    end

    // Zero length probe goes out as a write so no slave drives data
    always_ff @(posedge I2C_CLK) begin
        if (cstate == C_IDLE && req) begin
            cmd.f.addr <= addr_byte.f.addr;
            cmd.f.rw   <= addr_byte.f.rw && (length != '0);
            cmd_len    <= length;
        end
    end

    assign xfer.start     = (cstate == C_START) && !xfer.busy;
    assign xfer.addr_byte = cmd;
    assign xfer.length    = cmd_len;
    assign ack            = (cstate == C_ACK);

endmodule

//--- design/i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top
    import i2c_xfer_pkg::*;
#(
    parameter int MEM_BYTES = 16
)(
    input  logic                         I2C_CLK,
    input  logic                         RST,
    input  logic                         req,
    output logic                         ack,
    input  addr_byte_u                   addr_byte,
    input  logic [LEN_W-1:0]             length,
    output logic                         done,
    output logic                         no_ack,
    input  logic                         buf_we,
    input  logic [$clog2(MEM_BYTES)-1:0] buf_addr,
    input  logic [7:0]                   buf_wdata,
    output logic [7:0]                   buf_rdata,
    output logic                         scl_low,
    output logic                         sda_low,
    input  logic                         sda_in
);

    i2c_xfer_if xfer_bus ();
    i2c_mem_if #(.MEM_BYTES(MEM_BYTES)) mem_bus ();

    i2c_cmd_port u_cmd_port (
        .I2C_CLK   (I2C_CLK),
        .RST       (RST),
        .req       (req),
        .addr_byte (addr_byte),
        .length    (length),
        .ack       (ack),
        .done      (done),
        .no_ack    (no_ack),
        .xfer      (xfer_bus.port)
    );

    xfer_buffer #(.MEM_BYTES(MEM_BYTES)) u_buffer (
        .I2C_CLK   (I2C_CLK),
        .buf_we    (buf_we),
        .buf_addr  (buf_addr),
        .buf_wdata (buf_wdata),
        .buf_rdata (buf_rdata),
        .eng       (mem_bus.mem)
    );

    // The board forms the open-drain lines from the drive-low outputs
    i2c_bit_engine #(.MEM_BYTES(MEM_BYTES)) u_engine (
        .I2C_CLK (I2C_CLK),
        .RST     (RST),
        .xfer    (xfer_bus.engine),
        .mem     (mem_bus.engine),
        .sda_in  (sda_in),
        .scl_low (scl_low),
        .sda_low (sda_low)
    );

endmodule

//--- design/i2c_mem_if.sv
`timescale 1ns/1ps

interface i2c_mem_if #(
    parameter int MEM_BYTES = 16
)();

    localparam int AW = $clog2(MEM_BYTES);

    logic          en;
    logic          we;
    logic [AW-1:0] addr;
    logic [7:0]    wdata;
    // One cycle after en
    logic [7:0]    rdata;

    modport engine (
        output en, we, addr, wdata,
        input  rdata
    );

    modport mem (
        input  en, we, addr, wdata,
        output rdata
    );

endinterface

//--- design/i2c_xfer_if.sv
`timescale 1ns/1ps

interface i2c_xfer_if
    import i2c_xfer_pkg::*;
();

    logic             start;
    addr_byte_u       addr_byte;
    logic [LEN_W-1:0] length;
    logic             busy;
    logic             finished;
    // Valid together with finished
    logic             no_ack;

    modport port (
        output start, addr_byte, length,
        input  busy, finished, no_ack
    );

    modport engine (
        input  start, addr_byte, length,
        output busy, finished, no_ack
    );

endinterface

//--- design/i2c_xfer_pkg.sv
package i2c_xfer_pkg;

    // Byte count of one transfer
    localparam int LEN_W = 8;

    // Address byte as seen by the host
    typedef struct packed {
        logic [6:0] addr;
        logic       rw;
    } addr_fields_t;

    // First byte on the wire, MSB first
    typedef union packed {
        logic [7:0]   raw;
        addr_fields_t f;
    } addr_byte_u;

endpackage

//--- design/xfer_buffer.sv
`timescale 1ns/1ps

module xfer_buffer #(
    parameter int MEM_BYTES = 16
)(
    input  logic                         I2C_CLK,
    input  logic                         buf_we,
    input  logic [$clog2(MEM_BYTES)-1:0] buf_addr,
    input  logic [7:0]                   buf_wdata,
    output logic [7:0]                   buf_rdata,
    i2c_mem_if.mem                       eng
);

    logic [7:0] mem [MEM_BYTES];

    // The handshake keeps host and engine writes apart
    always_ff @(posedge I2C_CLK) begin
        if (buf_we) begin
            mem[buf_addr] <= buf_wdata;
        end
        if (eng.en && eng.we) begin
            mem[eng.addr] <= eng.wdata;
        end
    end

    // Host read port
    always_ff @(posedge I2C_CLK) begin
        buf_rdata <= mem[buf_addr];
    end

    // Engine read holds its value between fetches
    always_ff @(posedge I2C_CLK) begin
        if (eng.en) begin
            eng.rdata <= mem[eng.addr];
        end
    end

endmodule

//--- i2c_master_top.f
design/i2c_bus_pkg.sv
design/i2c_xfer_pkg.sv
design/i2c_xfer_if.sv
design/i2c_mem_if.sv
design/i2c_cmd_port.sv
design/xfer_buffer.sv
design/i2c_bit_engine.sv
design/i2c_master_top.sv
test/i2c_slave_model.sv
test/i2c_master_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module i2c_master_tb \
    -f i2c_master_top.f -o sim_i2c_master &&
./obj_dir/sim_i2c_master || { echo "simulation failed"; exit 1; }

//--- test/i2c_master_tb.sv
`timescale 1ns/1ps

module i2c_master_tb
    import i2c_xfer_pkg::*;
();

    localparam int         MEM_BYTES = 16;
    localparam int         AW        = $clog2(MEM_BYTES);
    localparam int         N_ROWS    = 9;
    localparam logic [7:0] NO_NACK   = 8'hFF;

    // rw, address, length, slave present, NACK index, done, no_ack
    typedef struct packed {
        logic       rw;
        logic [6:0] addr;
        logic [7:0] len;
        logic       present;
        logic [7:0] nack_at;
        logic       exp_done;
        logic       exp_no_ack;
    } row_t;

    localparam row_t ROWS [N_ROWS] = '{
        '{1'b0, 7'h2A, 8'd4,  1'b1, NO_NACK, 1'b1, 1'b0},
        '{1'b1, 7'h2A, 8'd5,  1'b1, NO_NACK, 1'b1, 1'b0},
        '{1'b0, 7'h51, 8'd3,  1'b0, NO_NACK, 1'b0, 1'b1},
        '{1'b0, 7'h2A, 8'd6,  1'b1, 8'd2,    1'b0, 1'b1},
        '{1'b1, 7'h13, 8'd16, 1'b1, NO_NACK, 1'b1, 1'b0},
        '{1'b0, 7'h13, 8'd16, 1'b1, NO_NACK, 1'b1, 1'b0},
        // Address-only probe
        '{1'b0, 7'h2A, 8'd0,  1'b1, NO_NACK, 1'b1, 1'b0},
        '{1'b1, 7'h33, 8'd2,  1'b0, NO_NACK, 1'b0, 1'b1},
        '{1'b0, 7'h2A, 8'd1,  1'b1, 8'd0,    1'b0, 1'b1}
    };

    logic             I2C_CLK;
    logic             RST;
    logic             req;
    logic             ack;
    addr_byte_u       addr_byte;
    logic [LEN_W-1:0] length;
    logic             done;
    logic             no_ack;
    logic             buf_we;
    logic [AW-1:0]    buf_addr;
    logic [7:0]       buf_wdata;
    logic [7:0]       buf_rdata;
    logic             scl_low;
    logic             sda_low;
    logic             slave_sda_low;
    logic             bus_err;
    logic [6:0]       slave_addr;
    logic [7:0]       slave_nack;
    logic [7:0]       slave_tx [MEM_BYTES];
    logic [7:0]       exp_data [MEM_BYTES];
    logic             scl;
    logic             sda;

    // Open-drain lines with pull-ups
    assign scl = !scl_low;
    assign sda = !(sda_low || slave_sda_low);

    i2c_master_top #(.MEM_BYTES(MEM_BYTES)) u_dut (
        .I2C_CLK   (I2C_CLK),
        .RST       (RST),
        .req       (req),
        .ack       (ack),
        .addr_byte (addr_byte),
        .length    (length),
        .done      (done),
        .no_ack    (no_ack),
        .buf_we    (buf_we),
        .buf_addr  (buf_addr),
        .buf_wdata (buf_wdata),
        .buf_rdata (buf_rdata),
        .scl_low   (scl_low),
        .sda_low   (sda_low),
        .sda_in    (sda)
    );

    i2c_slave_model #(.BYTES(MEM_BYTES)) u_slave (
        .scl     (scl),
        .sda     (sda),
        .my_addr (slave_addr),
        .nack_at (slave_nack),
        .tx_data (slave_tx),
        .sda_low (slave_sda_low),
        .bus_err (bus_err)
    );

    initial begin
        I2C_CLK = 1'b0;
        forever #4 I2C_CLK = ~I2C_CLK;
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Bytes that cross the wire after the address byte
    function automatic int expected_bytes(input row_t r);
        if (!r.present)
            return 0;
        if (!r.rw && r.nack_at != NO_NACK)
            return int'(r.nack_at) + 1;
        return int'(r.len);
    endfunction

    function automatic int watchdog_cycles();
        int total;
        int i;
        total = 0;
        for (i = 0; i < N_ROWS; i++)
            total += (int'(ROWS[i].len) * 9 + 11) * 4 + 50;
        return total;
    endfunction

    task automatic fill_buffer(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            @(negedge I2C_CLK);
            exp_data[i] = 8'($urandom);
            buf_we      = 1'b1;
            buf_addr    = i[AW-1:0];
            buf_wdata   = exp_data[i];
        end
        @(negedge I2C_CLK);
        buf_we = 1'b0;
    endtask

    task automatic load_slave(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            exp_data[i] = 8'($urandom);
            slave_tx[i] = exp_data[i];
        end
    endtask

    task automatic run_command(input row_t r, input int row_no);
        int hold;
        @(negedge I2C_CLK);
        addr_byte.f.addr = r.addr;
        addr_byte.f.rw   = r.rw;
        length           = r.len;
        slave_addr       = r.present ? r.addr : r.addr ^ 7'h40;
        slave_nack       = r.nack_at;
        req              = 1'b1;
        @(negedge I2C_CLK);
        while (!ack)
            @(negedge I2C_CLK);
        // The stop must already be on the wire
        check_equal("slave starts", row_no + 1, u_slave.starts);
        check_equal("slave stops", row_no + 1, u_slave.stops);
        check_equal("done", r.exp_done, done);
        check_equal("no_ack", r.exp_no_ack, no_ack);
        hold = 1 + $urandom % 4;
        repeat (hold) begin
            @(negedge I2C_CLK);
            check_equal("ack", 1, ack);
        end
        req = 1'b0;
        @(negedge I2C_CLK);
        while (ack)
            @(negedge I2C_CLK);
        check_equal("done after ack", r.exp_done, done);
    endtask

    task automatic check_result(input row_t r);
        int i;
        int n_bytes;
        n_bytes = expected_bytes(r);
        check_equal("scl pulses", 10 + 9 * n_bytes, u_slave.pulses);
        check_equal("scl", 1, scl);
        check_equal("sda", 1, sda);
        if (r.rw) begin
            check_equal("slave rx count", 0, u_slave.rx_cnt);
            for (i = 0; i < n_bytes; i++) begin
                @(negedge I2C_CLK);
                buf_addr = i[AW-1:0];
                @(negedge I2C_CLK);
                check_equal("buf_rdata", exp_data[i], buf_rdata);
                check_equal("master ack", i < n_bytes - 1, u_slave.mack[i]);
            end
        end else begin
            check_equal("slave rx count", n_bytes, u_slave.rx_cnt);
            for (i = 0; i < n_bytes; i++)
                check_equal("slave rx byte", exp_data[i], u_slave.rx_data[i]);
        end
    endtask

    always @(posedge ack) begin
        if (!req) begin
            $display("ack rose while req was low");
            $display("test failed");
            $fatal(1, "handshake error");
        end
    end

    always @(posedge bus_err) begin
        $display("the slave model saw an illegal bus condition");
        $display("test failed");
        $fatal(1, "bus error");
    end

    initial begin
        repeat (watchdog_cycles()) @(posedge I2C_CLK);
        $display("watchdog expired after %0d cycles, a transfer never finished",
                 watchdog_cycles());
        $display("test failed");
        $fatal(1, "timeout");
    end

    initial begin
        int i;
        void'($urandom(32'h00351692));
        RST        = 1'b1;
        req        = 1'b0;
        addr_byte  = '0;
        length     = '0;
        buf_we     = 1'b0;
        buf_addr   = '0;
        buf_wdata  = '0;
        slave_addr = '0;
        slave_nack = NO_NACK;
        for (i = 0; i < MEM_BYTES; i++)
            slave_tx[i] = '0;
        repeat (2) @(negedge I2C_CLK);
        RST = 1'b0;
        check_equal("scl_low", 0, scl_low);
        check_equal("sda_low", 0, sda_low);
        for (i = 0; i < N_ROWS; i++) begin
            if (ROWS[i].rw)
                load_slave(ROWS[i].len);
            else
                fill_buffer(ROWS[i].len);
            run_command(ROWS[i], i);
            check_result(ROWS[i]);
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- test/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter int BYTES = 16
)(
    input  logic       scl,
    input  logic       sda,
    input  logic [6:0] my_addr,
    input  logic [7:0] nack_at,
    input  logic [7:0] tx_data [BYTES],
    output logic       sda_low,
    output logic       bus_err
);

    logic [7:0] rx_data [BYTES];
    // Master acknowledge per read byte, 1 means ACK
    logic       mack [BYTES];
    int         rx_cnt = 0;
    int         pulses = 0;
    int         starts = 0;
    int         stops = 0;
    logic       in_xfer = 1'b0;
    logic       matched = 1'b0;
    logic       rd_mode = 1'b0;
    logic       quiet = 1'b0;
    logic       drive = 1'b0;
    logic       err = 1'b0;
    logic       scl_q = 1'b1;
    logic       sda_q = 1'b1;
    logic [7:0] shreg = '0;

    assign sda_low = drive;
    assign bus_err = err;

    task automatic flag_bus_error(input string what);
        $display("bus error at %0t: %s", $time, what);
        err = 1'b1;
    endtask

    // Slot 0..7 are data bits, slot 8 is the acknowledge
    always @(posedge scl or negedge scl or posedge sda or negedge sda) begin : bus_watch
        int pos;
        int byte_no;
        if (scl && scl_q && sda != sda_q) begin
            if (!sda) begin
                if (in_xfer)
                    flag_bus_error("repeated start inside a transfer");
                in_xfer = 1'b1;
                starts++;
                pulses  = 0;
                rx_cnt  = 0;
                matched = 1'b0;
                rd_mode = 1'b0;
                quiet   = 1'b0;
            end else begin
                if (!in_xfer)
                    flag_bus_error("stop without a start");
                in_xfer = 1'b0;
                stops++;
            end
            drive = 1'b0;
        end else if (scl && !scl_q && in_xfer && pulses > 0) begin
            pos     = (pulses - 1) % 9;
            byte_no = (pulses - 1) / 9;
            if (pos < 8) begin
                shreg = {shreg[6:0], sda};
            end else if (byte_no > 0 && matched && rd_mode) begin
                mack[byte_no - 1] = !sda;
                quiet = sda;
            end
        end else if (!scl && scl_q) begin
            if (!in_xfer)
                flag_bus_error("SCL pulse outside a transfer");
            pulses++;
            pos     = (pulses - 1) % 9;
            byte_no = (pulses - 1) / 9;
            drive   = 1'b0;
            if (pos == 8 && byte_no == 0) begin
                matched = (shreg[7:1] == my_addr);
                rd_mode = shreg[0];
                drive   = matched;
            end else if (pos == 8 && matched && !rd_mode) begin
                rx_data[byte_no - 1] = shreg;
                rx_cnt++;
                drive = ((byte_no - 1) != int'(nack_at));
            end else if (pos < 8 && byte_no > 0 && matched && rd_mode && !quiet) begin
                drive = !tx_data[byte_no - 1][7 - pos];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule
